//--- verilog/rt_pkg.sv
`default_nettype none

package rt_pkg;

  // ------------------------------------------------------------------------
  // sizes
  // ------------------------------------------------------------------------
  localparam int unsigned NumRegions = 2;
  localparam int unsigned NumRules   = 4;
  localparam int unsigned NumPending = 8;

  // channel field widths
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned LenWidth    = 8;
  localparam int unsigned SizeWidth   = 3;
  localparam int unsigned BudgetWidth = 16;
  localparam int unsigned PeriodWidth = 16;

  // largest request is 256 beats of 128 bytes
  localparam int unsigned BytesWidth     = LenWidth + 2**SizeWidth;
  localparam int unsigned RegionIdxWidth = $clog2(NumRegions);
  localparam int unsigned PendingWidth   = $clog2(NumPending + 1);

  // ------------------------------------------------------------------------
  // types
  // ------------------------------------------------------------------------
  typedef logic [AddrWidth-1:0]      addr_t;
  typedef logic [LenWidth-1:0]       len_t;
  typedef logic [SizeWidth-1:0]      size_t;
  typedef logic [BytesWidth-1:0]     ax_bytes_t;
  typedef logic [BudgetWidth-1:0]    budget_t;
  typedef logic [PeriodWidth-1:0]    period_t;
  typedef logic [RegionIdxWidth-1:0] region_idx_t;
  typedef logic [PendingWidth-1:0]   pending_t;

endpackage

`default_nettype wire

//--- verilog/rt_ax_if.sv
`timescale 1ns/10ps
`default_nettype none

// one address channel, aw or ar
interface rt_ax_if import rt_pkg::*;;

  logic  valid;
  logic  ready;
  addr_t addr;
  len_t  len;
  size_t size;

  modport manager (
    output valid, addr, len, size,
    input  ready
  );

  modport subordinate (
    input  valid, addr, len, size,
    output ready
  );

endinterface

`default_nettype wire

//--- verilog/rt_isolate.sv
`timescale 1ns/10ps
`default_nettype none

module rt_isolate import rt_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_n_i,
  input  wire logic       isolate_i,
  rt_ax_if.subordinate    slv_aw,
  rt_ax_if.subordinate    slv_ar,
  rt_ax_if.manager        mst_aw,
  rt_ax_if.manager        mst_ar,
  input  wire logic       aw_done_i,
  input  wire logic       ar_done_i,
  output logic            isolated_o
);

  pending_t aw_pending_q;
  pending_t ar_pending_q;
  logic     aw_block;
  logic     ar_block;
  logic     aw_fire;
  logic     ar_fire;

  // up on handshake, down on done; stray done is dropped
  function automatic pending_t next_pending(pending_t cnt, logic up, logic down);
    pending_t nxt;
    logic     dec;
    nxt = cnt;
    dec = down && (cnt != '0);
    if (up && !dec) begin
      nxt = cnt + 1'b1;
    end else if (!up && dec) begin
      nxt = cnt - 1'b1;
    end
    return nxt;
  endfunction

  // ------------------------------------------------------------------------
  // gate
  // ------------------------------------------------------------------------
  // a full counter also stalls its own channel
  assign aw_block = isolate_i | (aw_pending_q == pending_t'(NumPending));
  assign ar_block = isolate_i | (ar_pending_q == pending_t'(NumPending));

  assign mst_aw.valid = slv_aw.valid & ~aw_block;
  assign mst_aw.addr  = slv_aw.addr;
  assign mst_aw.len   = slv_aw.len;
  assign mst_aw.size  = slv_aw.size;
  assign slv_aw.ready = mst_aw.ready & ~aw_block;

  assign mst_ar.valid = slv_ar.valid & ~ar_block;
  assign mst_ar.addr  = slv_ar.addr;
  assign mst_ar.len   = slv_ar.len;
  assign mst_ar.size  = slv_ar.size;
  assign slv_ar.ready = mst_ar.ready & ~ar_block;

  assign aw_fire = mst_aw.valid & mst_aw.ready;
  assign ar_fire = mst_ar.valid & mst_ar.ready;

  // outstanding transactions
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      aw_pending_q <= '0;
      ar_pending_q <= '0;
    end else begin
      aw_pending_q <= next_pending(aw_pending_q, aw_fire, aw_done_i);
      ar_pending_q <= next_pending(ar_pending_q, ar_fire, ar_done_i);
    end
  end

  assign isolated_o = isolate_i & (aw_pending_q == '0) & (ar_pending_q == '0);

  a_pending_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (aw_pending_q <= pending_t'(NumPending)) && (ar_pending_q <= pending_t'(NumPending)));

  // subordinate must not complete more than it accepted
  a_no_orphan_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (aw_done_i |-> aw_pending_q != '0) and (ar_done_i |-> ar_pending_q != '0))
    else $error("done pulse with nothing outstanding");

endmodule

`default_nettype wire

//--- verilog/rt_region_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rt_region_decode import rt_pkg::*; (
  input  wire addr_t                      addr_i,
  input  wire addr_t       [NumRules-1:0] rule_start_i,
  input  wire addr_t       [NumRules-1:0] rule_end_i,
  input  wire region_idx_t [NumRules-1:0] rule_region_i,
  output region_idx_t                     region_o,
  output logic                            match_o
);

  logic [NumRules-1:0] hit;

  // half-open ranges, end is exclusive
  always_comb begin
    for (int i = 0; i < NumRules; i++) begin
      hit[i] = (addr_i >= rule_start_i[i]) && (addr_i < rule_end_i[i]);
    end
  end

  // walk down so the lowest matching rule wins
  always_comb begin
    region_o = '0;
    match_o  = 1'b0;
    for (int i = NumRules - 1; i >= 0; i--) begin
      if (hit[i]) begin
        region_o = rule_region_i[i];
        match_o  = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/rt_budget_counter.sv
`timescale 1ns/10ps
`default_nettype none

module rt_budget_counter import rt_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_n_i,
  input  wire logic      enable_i,
  input  wire logic      charge_i,
  input  wire ax_bytes_t bytes_i,
  input  wire logic      abort_i,
  input  wire budget_t   budget_i,
  input  wire period_t   period_i,
  output budget_t        budget_left_o,
  output period_t        period_left_o,
  output logic           spent_o
);

  period_t period_left_q;
  budget_t budget_left_q;
  logic    spent_q;
  logic    reload;
  logic    exhaust;
  budget_t charge_bytes;

  // period expired or cut short
  assign reload       = enable_i & ((period_left_q == '0) | abort_i);
  assign charge_bytes = budget_t'(bytes_i);
  assign exhaust      = charge_bytes >= budget_left_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      period_left_q <= '0;
      budget_left_q <= '0;
      spent_q       <= 1'b0;
    end else if (reload) begin
      // a charge in this cycle is dropped
      period_left_q <= period_i;
      budget_left_q <= budget_i;
      spent_q       <= 1'b0;
    end else if (enable_i) begin
      period_left_q <= period_left_q - 1'b1;
      if (charge_i && !spent_q) begin
        if (exhaust) begin
          // saturate at zero
          budget_left_q <= '0;
          spent_q       <= 1'b1;
        end else begin
          budget_left_q <= budget_left_q - charge_bytes;
        end
      end
    end
  end

  assign period_left_o = period_left_q;
  assign budget_left_o = budget_left_q;
  assign spent_o       = spent_q;

  // budget only ever grows through a load of budget_i
  a_budget_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$past(reload) |-> budget_left_q <= $past(budget_left_q));

endmodule

`default_nettype wire

//--- verilog/rt_bypass_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module rt_bypass_fsm (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  input  wire logic rt_enable_i,
  input  wire logic isolated_i,
  output logic      isolate_o,
  output logic      bypassed_o
);

  typedef enum logic [1:0] {
    IDLE,
    ISOLATE,
    SWITCH,
    DEISOLATE
  } rt_state_e;

  rt_state_e state_q, state_d;
  logic      bypassed_q, bypassed_d;

  always_comb begin
    state_d    = state_q;
    bypassed_d = bypassed_q;
    isolate_o  = 1'b0;
    unique case (state_q)
      IDLE: begin
        // requested mode differs from current one
        if (rt_enable_i == bypassed_q) begin
          state_d = ISOLATE;
        end
      end
      ISOLATE: begin
        isolate_o = 1'b1;
        if (isolated_i) begin
          state_d = SWITCH;
        end
      end
      SWITCH: begin
        isolate_o  = 1'b1;
        bypassed_d = ~bypassed_q;
        state_d    = DEISOLATE;
      end
      DEISOLATE: begin
        if (!isolated_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      bypassed_q <= 1'b1;
    end else begin
      state_q    <= state_d;
      bypassed_q <= bypassed_d;
    end
  end

  assign bypassed_o = bypassed_q;

endmodule

`default_nettype wire

//--- verilog/rt_unit.sv
`timescale 1ns/10ps
`default_nettype none

module rt_unit import rt_pkg::*; (
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,
  // manager side
  input  wire logic                          slv_aw_valid_i,
  output logic                               slv_aw_ready_o,
  input  wire addr_t                         slv_aw_addr_i,
  input  wire len_t                          slv_aw_len_i,
  input  wire size_t                         slv_aw_size_i,
  input  wire logic                          slv_ar_valid_i,
  output logic                               slv_ar_ready_o,
  input  wire addr_t                         slv_ar_addr_i,
  input  wire len_t                          slv_ar_len_i,
  input  wire size_t                         slv_ar_size_i,
  // subordinate side
  output logic                               mst_aw_valid_o,
  input  wire logic                          mst_aw_ready_i,
  output addr_t                              mst_aw_addr_o,
  output len_t                               mst_aw_len_o,
  output size_t                              mst_aw_size_o,
  output logic                               mst_ar_valid_o,
  input  wire logic                          mst_ar_ready_i,
  output addr_t                              mst_ar_addr_o,
  output len_t                               mst_ar_len_o,
  output size_t                              mst_ar_size_o,
  input  wire logic                          aw_done_i,
  input  wire logic                          ar_done_i,
  // mode and throttling control
  input  wire logic                          rt_enable_i,
  output logic                               rt_bypassed_o,
  input  wire logic                          imtu_enable_i,
  input  wire logic                          imtu_abort_i,
  input  wire addr_t       [NumRules-1:0]    rule_start_i,
  input  wire addr_t       [NumRules-1:0]    rule_end_i,
  input  wire region_idx_t [NumRules-1:0]    rule_region_i,
  input  wire budget_t     [NumRegions-1:0]  w_budget_i,
  input  wire period_t     [NumRegions-1:0]  w_period_i,
  input  wire budget_t     [NumRegions-1:0]  r_budget_i,
  input  wire period_t     [NumRegions-1:0]  r_period_i,
  output budget_t          [NumRegions-1:0]  w_budget_left_o,
  output period_t          [NumRegions-1:0]  w_period_left_o,
  output budget_t          [NumRegions-1:0]  r_budget_left_o,
  output period_t          [NumRegions-1:0]  r_period_left_o,
  output logic                               w_decode_error_o,
  output logic                               r_decode_error_o,
  output logic                               isolate_o,
  output logic                               isolated_o
);

  rt_ax_if slv_aw ();
  rt_ax_if slv_ar ();
  rt_ax_if mst_aw ();
  rt_ax_if mst_ar ();

  logic                  byp_isolate;
  logic                  spent_isolate;
  logic                  rt_bypassed;
  logic                  cnt_enable;
  logic [NumRegions-1:0] w_spent;
  logic [NumRegions-1:0] r_spent;
  ax_bytes_t             aw_bytes;
  ax_bytes_t             ar_bytes;
  logic                  aw_fire;
  logic                  ar_fire;
  region_idx_t           aw_region;
  region_idx_t           ar_region;
  logic                  aw_match;
  logic                  ar_match;

  // ------------------------------------------------------------------------
  // port mapping
  // ------------------------------------------------------------------------
  assign slv_aw.valid   = slv_aw_valid_i;
  assign slv_aw.addr    = slv_aw_addr_i;
  assign slv_aw.len     = slv_aw_len_i;
  assign slv_aw.size    = slv_aw_size_i;
  assign slv_aw_ready_o = slv_aw.ready;
  assign slv_ar.valid   = slv_ar_valid_i;
  assign slv_ar.addr    = slv_ar_addr_i;
  assign slv_ar.len     = slv_ar_len_i;
  assign slv_ar.size    = slv_ar_size_i;
  assign slv_ar_ready_o = slv_ar.ready;

  assign mst_aw_valid_o = mst_aw.valid;
  assign mst_aw_addr_o  = mst_aw.addr;
  assign mst_aw_len_o   = mst_aw.len;
  assign mst_aw_size_o  = mst_aw.size;
  assign mst_aw.ready   = mst_aw_ready_i;
  assign mst_ar_valid_o = mst_ar.valid;
  assign mst_ar_addr_o  = mst_ar.addr;
  assign mst_ar_len_o   = mst_ar.len;
  assign mst_ar_size_o  = mst_ar.size;
  assign mst_ar.ready   = mst_ar_ready_i;

  // ------------------------------------------------------------------------
  // mode control and isolation
  // ------------------------------------------------------------------------
  rt_bypass_fsm i_bypass_fsm (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .rt_enable_i ( rt_enable_i ),
    .isolated_i  ( isolated_o  ),
    .isolate_o   ( byp_isolate ),
    .bypassed_o  ( rt_bypassed )
  );

  assign rt_bypassed_o = rt_bypassed;
  assign cnt_enable    = imtu_enable_i & ~rt_bypassed;
  assign spent_isolate = ((|w_spent) | (|r_spent)) & cnt_enable;
  assign isolate_o     = spent_isolate;

  rt_isolate i_isolate (
    .clk_i      ( clk_i                       ),
    .rst_n_i    ( rst_n_i                     ),
    .isolate_i  ( spent_isolate | byp_isolate ),
    .slv_aw     ( slv_aw                      ),
    .slv_ar     ( slv_ar                      ),
    .mst_aw     ( mst_aw                      ),
    .mst_ar     ( mst_ar                      ),
    .aw_done_i  ( aw_done_i                   ),
    .ar_done_i  ( ar_done_i                   ),
    .isolated_o ( isolated_o                  )
  );

  // ------------------------------------------------------------------------
  // byte probes and decode, all on the subordinate side
  // ------------------------------------------------------------------------
  assign aw_bytes = (ax_bytes_t'(mst_aw.len) + ax_bytes_t'(1)) << mst_aw.size;
  assign ar_bytes = (ax_bytes_t'(mst_ar.len) + ax_bytes_t'(1)) << mst_ar.size;
  assign aw_fire  = mst_aw.valid & mst_aw.ready;
  assign ar_fire  = mst_ar.valid & mst_ar.ready;

  rt_region_decode i_decode_aw (
    .addr_i        ( mst_aw.addr   ),
    .rule_start_i  ( rule_start_i  ),
    .rule_end_i    ( rule_end_i    ),
    .rule_region_i ( rule_region_i ),
    .region_o      ( aw_region     ),
    .match_o       ( aw_match      )
  );

  rt_region_decode i_decode_ar (
    .addr_i        ( mst_ar.addr   ),
    .rule_start_i  ( rule_start_i  ),
    .rule_end_i    ( rule_end_i    ),
    .rule_region_i ( rule_region_i ),
    .region_o      ( ar_region     ),
    .match_o       ( ar_match      )
  );

  assign w_decode_error_o = mst_aw.valid & ~aw_match & ~rt_bypassed;
  assign r_decode_error_o = mst_ar.valid & ~ar_match & ~rt_bypassed;

  // one write and one read counter per region
  for (genvar r = 0; r < NumRegions; r++) begin : gen_region
    logic w_charge;
    logic r_charge;

    assign w_charge = aw_fire & aw_match & ~rt_bypassed & (aw_region == region_idx_t'(r));
    assign r_charge = ar_fire & ar_match & ~rt_bypassed & (ar_region == region_idx_t'(r));

    rt_budget_counter i_w_counter (
      .clk_i         ( clk_i              ),
      .rst_n_i       ( rst_n_i            ),
      .enable_i      ( cnt_enable         ),
      .charge_i      ( w_charge           ),
      .bytes_i       ( aw_bytes           ),
      .abort_i       ( imtu_abort_i       ),
      .budget_i      ( w_budget_i[r]      ),
      .period_i      ( w_period_i[r]      ),
      .budget_left_o ( w_budget_left_o[r] ),
      .period_left_o ( w_period_left_o[r] ),
      .spent_o       ( w_spent[r]         )
    );

    rt_budget_counter i_r_counter (
      .clk_i         ( clk_i              ),
      .rst_n_i       ( rst_n_i            ),
      .enable_i      ( cnt_enable         ),
      .charge_i      ( r_charge           ),
      .bytes_i       ( ar_bytes           ),
      .abort_i       ( imtu_abort_i       ),
      .budget_i      ( r_budget_i[r]      ),
      .period_i      ( r_period_i[r]      ),
      .budget_left_o ( r_budget_left_o[r] ),
      .period_left_o ( r_period_left_o[r] ),
      .spent_o       ( r_spent[r]         )
    );
  end

endmodule

`default_nettype wire

//--- tb/tb_rt_unit.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rt_unit import rt_pkg::*; ();

  localparam int ClkHalf = 20;
  localparam int Settle  = 2;
  localparam int Budget  = 1024;
  localparam int Period  = 200;

  logic                            clk_i;
  logic                            rst_n_i;
  logic                            slv_aw_valid_i;
  logic                            slv_aw_ready_o;
  addr_t                           slv_aw_addr_i;
  len_t                            slv_aw_len_i;
  size_t                           slv_aw_size_i;
  logic                            slv_ar_valid_i;
  logic                            slv_ar_ready_o;
  addr_t                           slv_ar_addr_i;
  len_t                            slv_ar_len_i;
  size_t                           slv_ar_size_i;
  logic                            mst_aw_valid_o;
  logic                            mst_aw_ready_i;
  addr_t                           mst_aw_addr_o;
  len_t                            mst_aw_len_o;
  size_t                           mst_aw_size_o;
  logic                            mst_ar_valid_o;
  logic                            mst_ar_ready_i;
  addr_t                           mst_ar_addr_o;
  len_t                            mst_ar_len_o;
  size_t                           mst_ar_size_o;
  logic                            aw_done_i;
  logic                            ar_done_i;
  logic                            rt_enable_i;
  logic                            rt_bypassed_o;
  logic                            imtu_enable_i;
  logic                            imtu_abort_i;
  addr_t       [NumRules-1:0]      rule_start_i;
  addr_t       [NumRules-1:0]      rule_end_i;
  region_idx_t [NumRules-1:0]      rule_region_i;
  budget_t     [NumRegions-1:0]    w_budget_i;
  period_t     [NumRegions-1:0]    w_period_i;
  budget_t     [NumRegions-1:0]    r_budget_i;
  period_t     [NumRegions-1:0]    r_period_i;
  budget_t     [NumRegions-1:0]    w_budget_left_o;
  period_t     [NumRegions-1:0]    w_period_left_o;
  budget_t     [NumRegions-1:0]    r_budget_left_o;
  period_t     [NumRegions-1:0]    r_period_left_o;
  logic                            w_decode_error_o;
  logic                            r_decode_error_o;
  logic                            isolate_o;
  logic                            isolated_o;

  logic [31:0] rnd_state;
  int          error_count;
  int          tests_run;
  int          tests_failed;

  rt_unit DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkHalf) clk_i = ~clk_i;
  end

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // bytes of a request: beats times beat width
  function automatic int unsigned expected_bytes(input len_t len, input size_t size);
    return (int'(len) + 1) * (32'd1 << size);
  endfunction

  function automatic int unsigned budget_left(input logic is_write, input int region);
    if (is_write) begin
      return w_budget_left_o[region];
    end
    return r_budget_left_o[region];
  endfunction

  function automatic string budget_name(input logic is_write, input int region);
    return $sformatf("%s_budget_left_o[%0d]", is_write ? "w" : "r", region);
  endfunction

  function automatic logic ready_seen(input logic is_write);
    if (is_write) begin
      return slv_aw_ready_o === 1'b1;
    end
    return slv_ar_ready_o === 1'b1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    error_count++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("%0t ns  %s: passed", $time, name);
    end else begin
      tests_failed++;
      $display("%0t ns  %s: %0d error(s)", $time, name, error_count - errs_before);
    end
  endtask

  // random address inside one rule range
  task automatic pick_addr(input int rule, output addr_t addr);
    rnd_state = xorshift32(rnd_state);
    addr = rule_start_i[rule] + (rnd_state & 32'h0fff_fff0);
  endtask

  task automatic drive_request(input logic is_write, input addr_t addr, input len_t len,
                               input size_t size);
    if (is_write) begin
      slv_aw_valid_i = 1'b1;
      slv_aw_addr_i  = addr;
      slv_aw_len_i   = len;
      slv_aw_size_i  = size;
    end else begin
      slv_ar_valid_i = 1'b1;
      slv_ar_addr_i  = addr;
      slv_ar_len_i   = len;
      slv_ar_size_i  = size;
    end
  endtask

  // valid already high; sample mid-cycle, transfer at the next rising edge
  task automatic await_transfer(input logic is_write, input addr_t addr, input len_t len,
                                input size_t size, input int max_cycles);
    int waited;
    waited = 0;
    #(Settle);
    while (!ready_seen(is_write) && waited < max_cycles) begin
      @(negedge clk_i);
      #(Settle);
      waited++;
    end
    assert (ready_seen(is_write)) else report_timeout("request handshake");
    if (ready_seen(is_write)) begin
      if (is_write) begin
        check_value("mst_aw_valid_o", mst_aw_valid_o, 1'b1);
        check_value("mst_aw_addr_o", mst_aw_addr_o, addr);
        check_value("mst_aw_len_o", mst_aw_len_o, len);
        check_value("mst_aw_size_o", mst_aw_size_o, size);
      end else begin
        check_value("mst_ar_valid_o", mst_ar_valid_o, 1'b1);
        check_value("mst_ar_addr_o", mst_ar_addr_o, addr);
        check_value("mst_ar_len_o", mst_ar_len_o, len);
        check_value("mst_ar_size_o", mst_ar_size_o, size);
      end
      @(posedge clk_i);
    end
    @(negedge clk_i);
    if (is_write) begin
      slv_aw_valid_i = 1'b0;
    end else begin
      slv_ar_valid_i = 1'b0;
    end
  endtask

  task automatic send_request(input logic is_write, input addr_t addr, input len_t len,
                              input size_t size, input int max_cycles);
    @(negedge clk_i);
    drive_request(is_write, addr, len, size);
    await_transfer(is_write, addr, len, size, max_cycles);
  endtask

  // subordinate completes one transaction
  task automatic pulse_done(input logic is_write);
    @(negedge clk_i);
    if (is_write) begin
      aw_done_i = 1'b1;
    end else begin
      ar_done_i = 1'b1;
    end
    @(negedge clk_i);
    aw_done_i = 1'b0;
    ar_done_i = 1'b0;
  endtask

  task automatic pulse_abort();
    @(negedge clk_i);
    imtu_abort_i = 1'b1;
    @(negedge clk_i);
    imtu_abort_i = 1'b0;
  endtask

  // ------------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------------
  task automatic test_reset_bypass();
    int    errs;
    addr_t a;
    errs = error_count;
    check_value("rt_bypassed_o", rt_bypassed_o, 1'b1);
    check_value("isolate_o", isolate_o, 1'b0);
    check_value("isolated_o", isolated_o, 1'b0);
    check_value("mst_aw_valid_o", mst_aw_valid_o, 1'b0);
    check_value("mst_ar_valid_o", mst_ar_valid_o, 1'b0);
    pick_addr(1, a);
    send_request(1'b1, a, 8'd7, 3'd2, 20);
    pulse_done(1'b1);
    for (int r = 0; r < NumRegions; r++) begin
      check_value(budget_name(1'b1, r), budget_left(1'b1, r), 0);
      check_value(budget_name(1'b0, r), budget_left(1'b0, r), 0);
    end
    finish_test("reset and bypass", errs);
  endtask

  task automatic test_rt_charge();
    int          errs;
    int          waited;
    int          region;
    logic        is_write;
    addr_t       a;
    len_t        len;
    size_t       size;
    errs = error_count;
    @(negedge clk_i);
    rt_enable_i = 1'b1;
    waited = 0;
    while (rt_bypassed_o !== 1'b0 && waited < 50) begin
      @(negedge clk_i);
      waited++;
    end
    assert (rt_bypassed_o === 1'b0) else report_timeout("rt_bypassed_o to fall");
    // start a fresh period, each request below hits a different counter
    pulse_abort();
    for (int k = 0; k < 4; k++) begin
      is_write = (k < 2);
      region   = k % 2;
      pick_addr(2 * region + k / 2, a);
      rnd_state = xorshift32(rnd_state);
      len  = len_t'(rnd_state[3:0]);
      size = size_t'(rnd_state[5:4]);
      send_request(is_write, a, len, size, 20);
      check_value(budget_name(is_write, region), budget_left(is_write, region),
                  Budget - expected_bytes(len, size));
      pulse_done(is_write);
    end
    finish_test("real-time charge", errs);
  endtask

  task automatic test_budget_exhaust();
    int    errs;
    int    waited;
    logic  leaked;
    addr_t a;
    errs = error_count;
    pulse_abort();
    // two writes of 512 bytes, rules 0 and 1 both map to region 0
    for (int k = 0; k < 2; k++) begin
      check_value("isolate_o", isolate_o, 1'b0);
      pick_addr(k, a);
      send_request(1'b1, a, 8'd63, 3'd3, 20);
      if (k == 0) begin
        check_value("w_budget_left_o[0]", w_budget_left_o[0],
                    Budget - expected_bytes(8'd63, 3'd3));
      end else begin
        check_value("isolate_o", isolate_o, 1'b1);
        check_value("w_budget_left_o[0]", w_budget_left_o[0], 0);
      end
      pulse_done(1'b1);
    end
    pick_addr(0, a);
    @(negedge clk_i);
    drive_request(1'b1, a, 8'd1, 3'd1);
    #(Settle);
    check_value("mst_aw_valid_o", mst_aw_valid_o, 1'b0);
    leaked = 1'b0;
    waited = 0;
    while (w_budget_left_o[0] !== budget_t'(Budget) && waited < 300) begin
      @(negedge clk_i);
      #(Settle);
      if (w_budget_left_o[0] !== budget_t'(Budget) && mst_aw_valid_o !== 1'b0) begin
        leaked = 1'b1;
      end
      waited++;
    end
    assert (w_budget_left_o[0] === budget_t'(Budget))
      else report_timeout("period reload of w_budget_left_o[0]");
    check_value("mst_aw_valid_o while spent", leaked, 1'b0);
    check_value("isolate_o", isolate_o, 1'b0);
    await_transfer(1'b1, a, 8'd1, 3'd1, 5);
    check_value("w_budget_left_o[0]", w_budget_left_o[0], Budget - expected_bytes(8'd1, 3'd1));
    pulse_done(1'b1);
    finish_test("budget exhaustion", errs);
  endtask

  task automatic test_decode_error();
    int    errs;
    addr_t a;
    errs = error_count;
    pulse_abort();
    rnd_state = xorshift32(rnd_state);
    // above every rule range
    a = 32'h8000_0000 + (rnd_state & 32'h0fff_fff0);
    @(negedge clk_i);
    drive_request(1'b1, a, 8'd1, 3'd2);
    #(Settle);
    check_value("w_decode_error_o", w_decode_error_o, 1'b1);
    check_value("r_decode_error_o", r_decode_error_o, 1'b0);
    await_transfer(1'b1, a, 8'd1, 3'd2, 20);
    #(Settle);
    check_value("w_decode_error_o", w_decode_error_o, 1'b0);
    for (int r = 0; r < NumRegions; r++) begin
      check_value(budget_name(1'b1, r), budget_left(1'b1, r), Budget);
      check_value(budget_name(1'b0, r), budget_left(1'b0, r), Budget);
    end
    pulse_done(1'b1);
    finish_test("decode error", errs);
  endtask

  task automatic test_abort_reload();
    int    errs;
    addr_t a;
    errs = error_count;
    pick_addr(3, a);
    send_request(1'b0, a, 8'd3, 3'd2, 20);
    check_value("r_budget_left_o[1]", r_budget_left_o[1], Budget - expected_bytes(8'd3, 3'd2));
    pulse_done(1'b0);
    repeat (5) @(negedge clk_i);
    pulse_abort();
    for (int r = 0; r < NumRegions; r++) begin
      check_value($sformatf("w_period_left_o[%0d]", r), w_period_left_o[r], Period);
      check_value($sformatf("r_period_left_o[%0d]", r), r_period_left_o[r], Period);
      check_value(budget_name(1'b1, r), budget_left(1'b1, r), Budget);
      check_value(budget_name(1'b0, r), budget_left(1'b0, r), Budget);
    end
    finish_test("abort reload", errs);
  endtask

  task automatic test_switch_outstanding();
    int    errs;
    int    waited;
    logic  early;
    addr_t a;
    errs = error_count;
    pick_addr(0, a);
    // leave this write outstanding
    send_request(1'b1, a, 8'd0, 3'd2, 20);
    @(negedge clk_i);
    rt_enable_i = 1'b0;
    early = 1'b0;
    repeat (12) begin
      @(negedge clk_i);
      if (isolated_o !== 1'b0 || rt_bypassed_o !== 1'b0) begin
        early = 1'b1;
      end
    end
    check_value("isolated_o or rt_bypassed_o before done", early, 1'b0);
    pulse_done(1'b1);
    waited = 0;
    while (rt_bypassed_o !== 1'b1 && waited < 50) begin
      @(negedge clk_i);
      waited++;
    end
    assert (rt_bypassed_o === 1'b1) else report_timeout("rt_bypassed_o to rise");
    finish_test("switch with outstanding write", errs);
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial begin
    rnd_state      = 32'hf8d3;
    error_count    = 0;
    tests_run      = 0;
    tests_failed   = 0;
    rst_n_i        = 1'b0;
    slv_aw_valid_i = 1'b0;
    slv_aw_addr_i  = '0;
    slv_aw_len_i   = '0;
    slv_aw_size_i  = '0;
    slv_ar_valid_i = 1'b0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
    slv_ar_size_i  = '0;
    mst_aw_ready_i = 1'b1;
    mst_ar_ready_i = 1'b1;
    aw_done_i      = 1'b0;
    ar_done_i      = 1'b0;
    rt_enable_i    = 1'b0;
    imtu_enable_i  = 1'b1;
    imtu_abort_i   = 1'b0;
    // rules 0 and 1 to region 0, rules 2 and 3 to region 1
    for (int i = 0; i < NumRules; i++) begin
      rule_start_i[i]  = 32'h2000_0000 * i;
      rule_end_i[i]    = 32'h2000_0000 * i + 32'h1000_0000;
      rule_region_i[i] = region_idx_t'(i / 2);
    end
    for (int r = 0; r < NumRegions; r++) begin
      w_budget_i[r] = budget_t'(Budget);
      r_budget_i[r] = budget_t'(Budget);
      w_period_i[r] = period_t'(Period);
      r_period_i[r] = period_t'(Period);
    end
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;

    test_reset_bypass();
    test_rt_charge();
    test_budget_exhaust();
    test_decode_error();
    test_abort_reload();
    test_switch_outstanding();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
verilog/rt_pkg.sv
verilog/rt_ax_if.sv
verilog/rt_isolate.sv
verilog/rt_region_decode.sv
verilog/rt_budget_counter.sv
verilog/rt_bypass_fsm.sv
verilog/rt_unit.sv
tb/tb_rt_unit.sv
